/* Bender.yml */
package:
  name: mrd_ctrl

sources:
  # RTL in compile order
  - logic/mrd_pkg.sv
  - logic/mrd_frame_sink.sv
  - logic/mrd_recip_div.sv
  - logic/mrd_factorizer.sv
  - logic/mrd_param_regs.sv
  - logic/mrd_ctrl_top.sv
  # testbench
  - target: test
    files:
      - verification/mrd_clk_gen.sv
      - verification/mrd_ctrl_assertions.sv
      - verification/mrd_ctrl_tb.sv

/* logic/mrd_ctrl_top.sv */
// DFT parameter controller top
// frame sink feeds the factorizer, results read over AXI4-Lite
`default_nettype none

module mrd_ctrl_top #(
  parameter int ADDR_W      = 8,
  parameter int RECIP_SHIFT = 20
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          sink_sop,
  input  logic                          sink_valid,
  input  logic [mrd_pkg::mrd_pts_w-1:0] dftpts,
  input  logic [ADDR_W-1:0]             araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [31:0]                   rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready
);
  import mrd_pkg::*;

  // ----------------------------------------
  // sink to factorizer
  // ----------------------------------------
  logic                 calc_start;
  logic [mrd_pts_w-1:0] frame_pts;
  logic                 sink_busy;
  logic                 overrun;

  // factorizer results
  logic [mrd_max_stages-1:0][2:0]             nf;
  logic [mrd_max_stages-1:0][mrd_pts_w-1:0]   dftpts_div_nf;
  logic [mrd_max_stages-1:0][mrd_pts_w-1:0]   twdl_demontr;
  logic [mrd_max_stages-1:0][mrd_recip_w-1:0] quotient;
  logic [mrd_max_stages-1:0][mrd_pts_w-1:0]   remainder;
  logic [2:0]                                 num_factors;
  logic [2:0]                                 stage_of_rdx2;
  logic                                       param_valid;
  logic                                       calc_busy;
  logic                                       factor_err;

  mrd_frame_sink u_frame_sink (
    .clk        (clk),
    .rst_n      (rst_n),
    .sink_sop   (sink_sop),
    .sink_valid (sink_valid),
    .dftpts     (dftpts),
    .calc_start (calc_start),
    .frame_pts  (frame_pts),
    .sink_busy  (sink_busy),
    .overrun    (overrun)
  );

  mrd_factorizer #(
    .RECIP_SHIFT (RECIP_SHIFT)
  ) u_factorizer (
    .clk           (clk),
    .rst_n         (rst_n),
    .calc_start    (calc_start),
    .frame_pts     (frame_pts),
    .nf            (nf),
    .dftpts_div_nf (dftpts_div_nf),
    .twdl_demontr  (twdl_demontr),
    .quotient      (quotient),
    .remainder     (remainder),
    .num_factors   (num_factors),
    .stage_of_rdx2 (stage_of_rdx2),
    .param_valid   (param_valid),
    .calc_busy     (calc_busy),
    .factor_err    (factor_err)
  );

  // register view of everything above
  mrd_param_regs #(
    .ADDR_W (ADDR_W)
  ) u_param_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .nf            (nf),
    .dftpts_div_nf (dftpts_div_nf),
    .twdl_demontr  (twdl_demontr),
    .quotient      (quotient),
    .remainder     (remainder),
    .num_factors   (num_factors),
    .stage_of_rdx2 (stage_of_rdx2),
    .param_valid   (param_valid),
    .calc_busy     (calc_busy),
    .factor_err    (factor_err),
    .sink_busy     (sink_busy),
    .overrun       (overrun)
  );

endmodule

`default_nettype wire

/* logic/mrd_factorizer.sv */
// factors the point count into radix 4/2/5/3 stages, one per cycle,
// then runs the reciprocal divide for each stage denominator
`default_nettype none

module mrd_factorizer #(
  parameter int RECIP_SHIFT = 20
) (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic                                                          calc_start,
  input  logic [mrd_pkg::mrd_pts_w-1:0]                                 frame_pts,
  output logic [mrd_pkg::mrd_max_stages-1:0][2:0]                       nf,
  output logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_pts_w-1:0]    dftpts_div_nf,
  output logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_pts_w-1:0]    twdl_demontr,
  output logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_recip_w-1:0]  quotient,
  output logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_pts_w-1:0]    remainder,
  output logic [2:0]                                                    num_factors,
  output logic [2:0]                                                    stage_of_rdx2,
  output logic                                                          param_valid,
  output logic                                                          calc_busy,
  output logic                                                          factor_err
);
  import mrd_pkg::*;

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_factor = 2'd1;
  localparam logic [1:0] st_divide = 2'd2;
  localparam logic [1:0] st_done   = 2'd3;

  localparam logic [mrd_pts_w-1:0] one   = 1;
  localparam logic [mrd_pts_w-1:0] div_3 = 3;
  localparam logic [mrd_pts_w-1:0] div_5 = 5;

  logic [1:0]             state;
  logic [mrd_pts_w-1:0]   work;
  logic [mrd_pts_w-1:0]   n_pts;
  logic [2:0]             fac;
  logic [mrd_pts_w-1:0]   work_q;
  logic [mrd_pts_w-1:0]   n_q;
  logic                   fac_step;
  logic [2:0]             slot;
  logic                   slot_live;
  logic [mrd_pts_w-1:0]   den;
  logic                   div_wait;
  logic                   div_start;
  logic                   div_done;
  logic [mrd_recip_w-1:0] div_q;
  logic [mrd_pts_w-1:0]   div_r;

  // ----------------------------------------
  // radix pick, 4 before 2 before 5 before 3
  // ----------------------------------------
  always_comb begin
    fac    = 3'd0;
    work_q = work;
    n_q    = n_pts;
    if (work[1:0] == 2'b00) begin
      fac    = 3'd4;
      work_q = work >> 2;
      n_q    = n_pts >> 2;
    end else if (!work[0]) begin
      fac    = 3'd2;
      work_q = work >> 1;
      n_q    = n_pts >> 1;
    end else if (work % div_5 == '0) begin
      fac    = 3'd5;
      work_q = work / div_5;
      n_q    = n_pts / div_5;
    end else if (work % div_3 == '0) begin
      fac    = 3'd3;
      work_q = work / div_3;
      n_q    = n_pts / div_3;
    end
  end

  // a factor can be placed this cycle
  assign fac_step = (state == st_factor) && (work != one) && (fac != 3'd0) &&
                    (num_factors < mrd_max_stages);

  // divide pointer runs over the used slots only
  assign slot_live = (slot < num_factors);
  assign den       = slot_live ? twdl_demontr[slot] : '0;
  assign div_start = (state == st_divide) && !div_wait && slot_live && (den > one);

  mrd_recip_div #(
    .RECIP_SHIFT (RECIP_SHIFT)
  ) u_recip_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_start (div_start),
    .divisor   (den),
    .div_done  (div_done),
    .quotient  (div_q),
    .remainder (div_r)
  );

  // ----------------------------------------
  // FSM and status
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= st_idle;
      num_factors   <= 3'd0;
      stage_of_rdx2 <= mrd_no_rdx2;
      param_valid   <= 1'b0;
      calc_busy     <= 1'b0;
      factor_err    <= 1'b0;
      slot          <= 3'd0;
      div_wait      <= 1'b0;
    end else if (calc_start) begin
      // restart from any state
      state         <= st_factor;
      num_factors   <= 3'd0;
      stage_of_rdx2 <= mrd_no_rdx2;
      param_valid   <= 1'b0;
      calc_busy     <= 1'b1;
      factor_err    <= 1'b0;
      slot          <= 3'd0;
      div_wait      <= 1'b0;
    end else begin
      case (state)
        st_factor: begin
          if (work == one) begin
            state <= st_divide;
          end else if (fac_step) begin
            num_factors <= num_factors + 3'd1;
            if (fac == 3'd2) begin
              stage_of_rdx2 <= num_factors;
            end
          end else begin
            // no allowed radix, or all six slots taken
            factor_err <= 1'b1;
            calc_busy  <= 1'b0;
            state      <= st_done;
          end
        end
        st_divide: begin
          if (!div_wait) begin
            if (!slot_live) begin
              param_valid <= 1'b1;
              calc_busy   <= 1'b0;
              state       <= st_done;
            end else if (div_start) begin
              div_wait <= 1'b1;
            end else begin
              slot <= slot + 3'd1;
            end
          end else if (div_done) begin
            div_wait <= 1'b0;
            slot     <= slot + 3'd1;
          end
        end
        default: begin
          // idle and done wait for calc_start
        end
      endcase
    end
  end

  // ----------------------------------------
  // tables
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (calc_start) begin
      work  <= frame_pts;
      n_pts <= frame_pts;
      for (int j = 0; j < mrd_max_stages; j++) begin
        nf[j]            <= 3'd1;
        dftpts_div_nf[j] <= frame_pts;
        twdl_demontr[j]  <= one;
        quotient[j]      <= '0;
        remainder[j]     <= '0;
      end
      // slot 0 denominator is always N
      twdl_demontr[0] <= frame_pts;
    end else if (fac_step) begin
      nf[num_factors]            <= fac;
      dftpts_div_nf[num_factors] <= n_q;
      // denominator is the working value before this radix
      twdl_demontr[num_factors]  <= work;
      work                       <= work_q;
    end else if ((state == st_divide) && div_wait && div_done) begin
      quotient[slot]  <= div_q;
      remainder[slot] <= div_r;
    end
  end

endmodule

`default_nettype wire

/* logic/mrd_frame_sink.sv */
// frame input side: latches the point count on the start beat,
// counts the frame's valid beats and flags a frame that starts too early
`default_nettype none

module mrd_frame_sink (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          sink_sop,
  input  logic                          sink_valid,
  input  logic [mrd_pkg::mrd_pts_w-1:0] dftpts,
  output logic                          calc_start,
  output logic [mrd_pkg::mrd_pts_w-1:0] frame_pts,
  output logic                          sink_busy,
  output logic                          overrun
);
  import mrd_pkg::*;

  logic                 start_beat;
  logic [mrd_pts_w-1:0] beat_cnt;
  logic [mrd_pts_w-1:0] beat_nxt;

  // start beat needs both sop and valid
  assign start_beat = sink_sop & sink_valid;
  assign beat_nxt   = beat_cnt + 1'b1;

  // point count for the factorizer
  always_ff @(posedge clk) begin
    if (start_beat) begin
      frame_pts <= dftpts;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      calc_start <= 1'b0;
      sink_busy  <= 1'b0;
      overrun    <= 1'b0;
      beat_cnt   <= '0;
    end else begin
      // one cycle after the start beat
      calc_start <= start_beat;
      if (start_beat) begin
        // sticky until the next start, clean start clears it
        overrun   <= sink_busy;
        // start beat is beat one
        beat_cnt  <= {{(mrd_pts_w-1){1'b0}}, 1'b1};
        // count 0 wraps to 4096 beats, single-point frame is done at once
        sink_busy <= (dftpts != {{(mrd_pts_w-1){1'b0}}, 1'b1});
      end else if (sink_valid && sink_busy) begin
        beat_cnt <= beat_nxt;
        if (beat_nxt == frame_pts) begin
          sink_busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mrd_param_regs.sv */
// AXI4-Lite read slave over the factorizer results
// summary, stage and reciprocal words, SLVERR on unmapped addresses
`default_nettype none

module mrd_param_regs #(
  parameter int ADDR_W = 8
) (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic [ADDR_W-1:0]                                             araddr,
  input  logic                                                          arvalid,
  output logic                                                          arready,
  output logic [31:0]                                                   rdata,
  output logic [1:0]                                                    rresp,
  output logic                                                          rvalid,
  input  logic                                                          rready,
  input  logic [mrd_pkg::mrd_max_stages-1:0][2:0]                       nf,
  input  logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_pts_w-1:0]    dftpts_div_nf,
  input  logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_pts_w-1:0]    twdl_demontr,
  input  logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_recip_w-1:0]  quotient,
  input  logic [mrd_pkg::mrd_max_stages-1:0][mrd_pkg::mrd_pts_w-1:0]    remainder,
  input  logic [2:0]                                                    num_factors,
  input  logic [2:0]                                                    stage_of_rdx2,
  input  logic                                                          param_valid,
  input  logic                                                          calc_busy,
  input  logic                                                          factor_err,
  input  logic                                                          sink_busy,
  input  logic                                                          overrun
);
  import mrd_pkg::*;

  mrd_reg_word_u     word;
  logic [1:0]        resp;
  logic [ADDR_W-1:0] off_stage;
  logic [ADDR_W-1:0] off_recip;
  logic [2:0]        j_stage;
  logic [2:0]        j_recip;
  logic              hit_sum;
  logic              hit_stage;
  logic              hit_recip;
  logic              ar_fire;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  // below-base addresses wrap high and miss
  assign off_stage = araddr - ADDR_W'(mrd_addr_stage);
  assign off_recip = araddr - ADDR_W'(mrd_addr_recip);
  assign j_stage   = off_stage[4:2];
  assign j_recip   = off_recip[4:2];
  assign hit_sum   = (araddr == ADDR_W'(mrd_addr_summary));
  assign hit_stage = (araddr[1:0] == 2'b00) && (off_stage[ADDR_W-1:2] < mrd_max_stages);
  assign hit_recip = (araddr[1:0] == 2'b00) && (off_recip[ADDR_W-1:2] < mrd_max_stages);

  // word build, live table contents
  always_comb begin
    word = '0;
    resp = mrd_resp_okay;
    if (hit_sum) begin
      word.summary.param_valid   = param_valid;
      // sample intake or calculation in progress
      word.summary.busy          = calc_busy | sink_busy;
      word.summary.factor_err    = factor_err;
      word.summary.overrun       = overrun;
      word.summary.num_factors   = num_factors;
      word.summary.stage_of_rdx2 = stage_of_rdx2;
      // slot 0 denominator holds N
      word.summary.dftpts        = twdl_demontr[0];
    end else if (hit_stage) begin
      word.stage.nf            = nf[j_stage];
      word.stage.dftpts_div_nf = dftpts_div_nf[j_stage];
      word.stage.twdl_demontr  = twdl_demontr[j_stage];
    end else if (hit_recip) begin
      word.recip.quotient  = quotient[j_recip];
      word.recip.remainder = remainder[j_recip];
    end else begin
      resp = mrd_resp_slverr;
    end
  end

  // ----------------------------------------
  // read channel
  // ----------------------------------------
  // one read outstanding, next address waits for rready
  assign arready = !rvalid;
  assign ar_fire = arvalid && arready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // response held until the handshake
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata <= word;
      rresp <= resp;
    end
  end

endmodule

`default_nettype wire

/* logic/mrd_pkg.sv */
// shared widths, register map and read word layouts
// for the mixed-radix DFT parameter controller
`default_nettype none

package mrd_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int mrd_max_stages = 6;
  localparam int mrd_pts_w      = 12;
  localparam int mrd_recip_w    = 20;

  // stage_of_rdx2 code when no radix-2 stage exists
  localparam logic [2:0] mrd_no_rdx2 = 3'd7;

  // ----------------------------------------
  // register map, byte offsets
  // ----------------------------------------
  localparam int mrd_addr_summary = 'h00;
  // stage word j at 0x04 + 4*j
  localparam int mrd_addr_stage   = 'h04;
  // reciprocal word j at 0x20 + 4*j
  localparam int mrd_addr_recip   = 'h20;

  // AXI response codes
  localparam logic [1:0] mrd_resp_okay   = 2'b00;
  localparam logic [1:0] mrd_resp_slverr = 2'b10;

  // one 32-bit read word, three decodings
  typedef union packed {
    struct packed {
      logic [9:0]           rsvd;
      logic                 param_valid;
      logic                 busy;
      logic                 factor_err;
      logic                 overrun;
      logic [2:0]           num_factors;
      logic [2:0]           stage_of_rdx2;
      logic [mrd_pts_w-1:0] dftpts;
    } summary;
    struct packed {
      logic [4:0]           rsvd;
      logic [2:0]           nf;
      logic [mrd_pts_w-1:0] dftpts_div_nf;
      logic [mrd_pts_w-1:0] twdl_demontr;
    } stage;
    struct packed {
      logic [mrd_recip_w-1:0] quotient;
      logic [mrd_pts_w-1:0]   remainder;
    } recip;
  } mrd_reg_word_u;

endpackage

`default_nettype wire

/* logic/mrd_recip_div.sv */
// restoring divider for 2**RECIP_SHIFT over a stage denominator
// one quotient bit per cycle, RECIP_SHIFT+1 cycles to div_done
`default_nettype none

module mrd_recip_div #(
  parameter int RECIP_SHIFT = 20
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            div_start,
  input  logic [mrd_pkg::mrd_pts_w-1:0]   divisor,
  output logic                            div_done,
  output logic [mrd_pkg::mrd_recip_w-1:0] quotient,
  output logic [mrd_pkg::mrd_pts_w-1:0]   remainder
);
  import mrd_pkg::*;

  localparam int cnt_w = $clog2(RECIP_SHIFT + 1);

  logic                 busy;
  logic [cnt_w-1:0]     bits_left;
  logic [mrd_pts_w-1:0] den_r;
  logic [mrd_pts_w-1:0] den_use;
  logic [mrd_pts_w-1:0] rem_in;
  logic [mrd_pts_w:0]   trial;
  logic                 q_bit;
  logic [mrd_pts_w-1:0] rem_nxt;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------
  // first step runs in the start cycle itself
  assign den_use = div_start ? divisor : den_r;
  assign rem_in  = div_start ? '0 : remainder;
  // dividend is a one then RECIP_SHIFT zeros, msb enters on start
  assign trial   = {rem_in, div_start};
  assign q_bit   = (trial >= {1'b0, den_use});
  // no-subtract case keeps trial below den, so it fits
  assign rem_nxt = q_bit ? mrd_pts_w'(trial - {1'b0, den_use})
                         : trial[mrd_pts_w-1:0];

  // ----------------------------------------
  // sequencing
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      div_done  <= 1'b0;
      bits_left <= '0;
    end else begin
      div_done <= 1'b0;
      // a new start aborts any job in flight
      if (div_start) begin
        busy      <= 1'b1;
        bits_left <= cnt_w'(RECIP_SHIFT);
      end else if (busy) begin
        bits_left <= bits_left - 1'b1;
        if (bits_left == cnt_w'(1)) begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  // partial remainder and quotient shift register
  always_ff @(posedge clk) begin
    if (div_start) begin
      den_r     <= divisor;
      remainder <= rem_nxt;
      quotient  <= mrd_recip_w'(q_bit);
    end else if (busy) begin
      remainder <= rem_nxt;
      quotient  <= {quotient[mrd_recip_w-2:0], q_bit};
    end
  end

endmodule

`default_nettype wire

/* mrd_ctrl_top.f */
logic/mrd_pkg.sv
logic/mrd_frame_sink.sv
logic/mrd_recip_div.sv
logic/mrd_factorizer.sv
logic/mrd_param_regs.sv
logic/mrd_ctrl_top.sv
verification/mrd_clk_gen.sv
verification/mrd_ctrl_assertions.sv
verification/mrd_ctrl_tb.sv

/* verification/mrd_clk_gen.sv */
// testbench clock and reset
// 10 ns clock, reset held low for the first 3 rising edges
`default_nettype none

module mrd_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // synchronous reset, released on an edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/mrd_ctrl_assertions.sv */
// AXI4-Lite read channel checks
// bound into the register slave of the parameter controller
`default_nettype none

module mrd_ctrl_assertions (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        arvalid,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rvalid,
  input  logic        rready
);
  timeunit 1ns;
  timeprecision 100ps;

  // failure count, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // ----------------------------------------
  // read channel
  // ----------------------------------------
  // single read outstanding
  a_arready_low: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> !arready)
    else begin
      fail_cnt++;
      $error("arready is high while rvalid is high");
    end

  // response held under back-pressure
  a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
      fail_cnt++;
      $error("read response changed or dropped while rready was low");
    end

  // address handshake gives rvalid next cycle
  a_rvalid_follows: assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid && arready) |=> rvalid)
    else begin
      fail_cnt++;
      $error("rvalid did not rise one cycle after the address handshake");
    end

  // and rvalid rises for no other reason
  a_rvalid_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rvalid) |-> $past(arvalid && arready))
    else begin
      fail_cnt++;
      $error("rvalid rose without an address handshake");
    end

  // reset clears the response
  a_reset_rvalid: assert property (@(posedge clk)
    !rst_n |=> !rvalid)
    else begin
      fail_cnt++;
      $error("rvalid is high after reset");
    end

endmodule

bind mrd_param_regs mrd_ctrl_assertions u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .arvalid (arvalid),
  .arready (arready),
  .rdata   (rdata),
  .rresp   (rresp),
  .rvalid  (rvalid),
  .rready  (rready)
);

`default_nettype wire

/* verification/mrd_ctrl_tb.sv */
// testbench for the DFT parameter controller
// sends frames, models the stage tables, reads them back over AXI4-Lite
`default_nettype none

module mrd_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mrd_pkg::*;

  localparam int addr_w      = 8;
  localparam int recip_shift = 20;
  // beats per frame in run order, last entry covers the extra reads
  localparam int frame_beats [10] = '{1200, 8, 60, 1024, 7, 4096, 20, 60, 60, 0};

  logic                 clk;
  logic                 rst_n;
  logic                 sink_sop;
  logic                 sink_valid;
  logic [mrd_pts_w-1:0] dftpts;
  logic [addr_w-1:0]    araddr;
  logic                 arvalid;
  logic                 arready;
  logic [31:0]          rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;

  int seed         = 32'h3914927f;
  int mismatch_cnt = 0;

  // expected tables
  int exp_nf   [mrd_max_stages];
  int exp_div  [mrd_max_stages];
  int exp_twdl [mrd_max_stages];
  int exp_quo  [mrd_max_stages];
  int exp_rem  [mrd_max_stages];
  int exp_cnt;
  int exp_rdx2;
  int exp_err;

  mrd_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mrd_ctrl_top #(
    .ADDR_W      (addr_w),
    .RECIP_SHIFT (recip_shift)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .sink_sop   (sink_sop),
    .sink_valid (sink_valid),
    .dftpts     (dftpts),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready)
  );

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  task automatic build_expected(input int pts);
    int n;
    int w;
    int f;
    // point count is 12 bits, 4096 arrives as 0
    n = pts & 'hfff;
    w = n;
    exp_cnt  = 0;
    exp_err  = 0;
    exp_rdx2 = mrd_no_rdx2;
    for (int j = 0; j < mrd_max_stages; j++) begin
      exp_nf[j]   = 1;
      exp_div[j]  = n;
      exp_twdl[j] = 1;
      exp_quo[j]  = 0;
      exp_rem[j]  = 0;
    end
    exp_twdl[0] = n;
    // radix order 4, 2, 5, 3
    while (w != 1 && exp_err == 0) begin
      if (w % 4 == 0) begin
        f = 4;
      end else if (w % 2 == 0) begin
        f = 2;
      end else if (w % 5 == 0) begin
        f = 5;
      end else if (w % 3 == 0) begin
        f = 3;
      end else begin
        f = 0;
      end
      if (f == 0 || exp_cnt == mrd_max_stages) begin
        exp_err = 1;
      end else begin
        if (exp_cnt > 0) begin
          exp_twdl[exp_cnt] = exp_twdl[exp_cnt-1] / exp_nf[exp_cnt-1];
        end
        exp_nf[exp_cnt]  = f;
        exp_div[exp_cnt] = n / f;
        if (f == 2) begin
          exp_rdx2 = exp_cnt;
        end
        w = w / f;
        exp_cnt++;
      end
    end
    // reciprocals only for a finished factorization
    if (exp_err == 0) begin
      for (int j = 0; j < exp_cnt; j++) begin
        if (exp_twdl[j] > 1) begin
          exp_quo[j] = (1 << recip_shift) / exp_twdl[j];
          exp_rem[j] = (1 << recip_shift) % exp_twdl[j];
        end
      end
    end
  endtask

  // ----------------------------------------
  // bus and frame drivers
  // ----------------------------------------
  function automatic logic pick_rready();
    // roughly one stall cycle in four
    return (($random(seed) & 3) != 0);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp)
      else begin
        mismatch_cnt++;
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
  endtask

  // start beat first, then plain valid beats
  task automatic send_beats(input int pts, input int beats);
    for (int i = 0; i < beats; i++) begin
      @(posedge clk);
      sink_sop   <= (i == 0);
      sink_valid <= 1'b1;
      dftpts     <= mrd_pts_w'(pts);
    end
    @(posedge clk);
    sink_sop   <= 1'b0;
    sink_valid <= 1'b0;
  endtask

  task automatic read_word(input logic [addr_w-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    logic done;
    done = 1'b0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    // wait for arready, handshake on the next edge
    @(negedge clk);
    while (!arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    rready  <= pick_rready();
    // random stalls on the data phase
    while (!done) begin
      @(negedge clk);
      if (rvalid && rready) begin
        data = rdata;
        resp = rresp;
        done = 1'b1;
      end
      @(posedge clk);
      rready <= done ? 1'b0 : pick_rready();
    end
  endtask

  // ----------------------------------------
  // read-back of one frame's results
  // ----------------------------------------
  task automatic check_results(input int pts, input logic exp_ovr);
    mrd_reg_word_u word;
    logic [31:0]   data;
    logic [1:0]    resp;
    build_expected(pts);
    word = '0;
    // poll until valid or error
    while (!word.summary.param_valid && !word.summary.factor_err) begin
      read_word(addr_w'(mrd_addr_summary), data, resp);
      word = data;
    end
    compare_value("rresp summary", resp, mrd_resp_okay);
    compare_value("param_valid", word.summary.param_valid, exp_err == 0);
    compare_value("busy", word.summary.busy, 0);
    compare_value("factor_err", word.summary.factor_err, exp_err);
    compare_value("overrun", word.summary.overrun, exp_ovr);
    compare_value("num_factors", word.summary.num_factors, exp_cnt);
    compare_value("stage_of_rdx2", word.summary.stage_of_rdx2, exp_rdx2);
    compare_value("dftpts", word.summary.dftpts, pts & 'hfff);
    for (int j = 0; j < mrd_max_stages; j++) begin
      read_word(addr_w'(mrd_addr_stage + 4 * j), data, resp);
      word = data;
      compare_value($sformatf("rresp stage %0d", j), resp, mrd_resp_okay);
      compare_value($sformatf("nf[%0d]", j), word.stage.nf, exp_nf[j]);
      compare_value($sformatf("dftpts_div_nf[%0d]", j), word.stage.dftpts_div_nf, exp_div[j]);
      compare_value($sformatf("twdl_demontr[%0d]", j), word.stage.twdl_demontr, exp_twdl[j]);
      read_word(addr_w'(mrd_addr_recip + 4 * j), data, resp);
      word = data;
      compare_value($sformatf("rresp recip %0d", j), resp, mrd_resp_okay);
      compare_value($sformatf("quotient[%0d]", j), word.recip.quotient, exp_quo[j]);
      compare_value($sformatf("remainder[%0d]", j), word.recip.remainder, exp_rem[j]);
    end
  endtask

  task automatic check_unmapped(input logic [addr_w-1:0] addr);
    logic [31:0] data;
    logic [1:0]  resp;
    read_word(addr, data, resp);
    compare_value($sformatf("rresp at 0x%0h", addr), resp, mrd_resp_slverr);
    compare_value($sformatf("rdata at 0x%0h", addr), data, 32'h0);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : stimulus
    int assert_fails;
    sink_sop   = 1'b0;
    sink_valid = 1'b0;
    dftpts     = '0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    @(posedge clk);
    while (!rst_n) begin
      @(posedge clk);
    end
    // radix 4, 4, 5, 5, 3
    send_beats(1200, 1200);
    check_results(1200, 1'b0);
    // radix-2 placement and unused slots
    send_beats(8, 8);
    check_results(8, 1'b0);
    send_beats(60, 60);
    check_results(60, 1'b0);
    send_beats(1024, 1024);
    check_results(1024, 1'b0);
    // no allowed radix
    send_beats(7, 7);
    check_results(7, 1'b0);
    // too many slots, wraps to 0 on the 12-bit port
    send_beats(4096, 4096);
    check_results(4096, 1'b0);
    // start beat mid-frame, then a clean frame
    send_beats(60, 20);
    send_beats(60, 60);
    check_results(60, 1'b1);
    send_beats(60, 60);
    check_results(60, 1'b0);
    // unmapped words, then a second stalled pass over the tables
    check_unmapped(addr_w'('h1c));
    check_unmapped(addr_w'('h02));
    check_unmapped(addr_w'('h40));
    check_unmapped(addr_w'('hfc));
    check_results(60, 1'b0);
    assert_fails = UUT.u_param_regs.u_assert.fail_cnt;
    $display("Done: %0d mismatches, %0d assertion failures", mismatch_cnt, assert_fails);
    if (mismatch_cnt == 0 && assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // budget of frame length plus 200 cycles per frame
  initial begin : watchdog
    int total;
    total = 0;
    foreach (frame_beats[i]) begin
      total += frame_beats[i] + 200;
    end
    #(total * 10);
    $display("Timeout: the run did not finish within %0d clock cycles", total);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
